//--- posit_div_pkg.sv
/* Shared constants of the posit divider: word size, reciprocal seed
   table geometry and pipeline depth */
`default_nettype none

package posit_div_pkg;

	//////////////////////////////////////////////////////////////////////
	// Word format
	//////////////////////////////////////////////////////////////////////

	// Fixed 16-bit posit, the reciprocal widths below only hold for this size
	localparam int POSIT_N = 16;

	// Width of a regime run count
	localparam logic [3:0] LOG2_N = 4'($clog2(POSIT_N));

	// Per module, from ES:
	//   mantissa width = POSIT_N - ES
	//   scale width    = LOG2_N + ES + 2 (signed regime joined to exponent)

	//////////////////////////////////////////////////////////////////////
	// Reciprocal seed table
	//////////////////////////////////////////////////////////////////////

	localparam int RECIP_AW = 8;    // Top fraction bits of the divisor
	localparam int RECIP_DW = 9;    // Seed is 0.ddddddddd

	//////////////////////////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////////////////////////

	// Decode, divide and encode register stages
	localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire

//--- posit_decode.sv
/* Input stage: zero and NaR tests, regime, exponent and mantissa unpacking
   of both operands, first pipeline register */
`timescale 1ns/1ns
`default_nettype none

module posit_decode #(
	parameter int ES = 2,
	localparam int N = posit_div_pkg::POSIT_N,
	localparam int MANT_W = N - ES,
	localparam int SCALE_W = posit_div_pkg::LOG2_N + ES + 2
) (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      start_i,
	input  logic [N-1:0]              in1_i,
	input  logic [N-1:0]              in2_i,
	output logic                      vld_o,
	output logic                      sign_o,
	output logic                      inf_o,
	output logic                      zero_o,
	output logic signed [SCALE_W-1:0] scale1_o,
	output logic signed [SCALE_W-1:0] scale2_o,
	output logic [MANT_W:0]           mant1_o,
	output logic [MANT_W:0]           mant2_o
);
	localparam int LW = posit_div_pkg::LOG2_N;

	// Leading-one search, halving the window at each level of the tree
	function automatic logic [LW-1:0] lead_zeros(input logic [N-1:0] v);
		logic [N-1:0] w;
		logic [LW-1:0] cnt;
		w = v;
		for (int lvl = LW - 1; lvl >= 0; lvl--) begin
			cnt[lvl] = ~|(w >> (N - (1 << lvl)));
			if (cnt[lvl])
				w = w << (1 << lvl);
		end
		return cnt;
	endfunction

	logic [N-1:0] op [2];
	logic op_nz [2];
	logic op_nar [2];
	logic op_zero [2];
	logic signed [SCALE_W-1:0] op_scale [2];
	logic [MANT_W:0] op_mant [2];

	assign op[0] = in1_i;
	assign op[1] = in2_i;

	for (genvar i = 0; i < 2; i++) begin : g_op
		logic [N-1:0] mag;
		logic [N-1:0] mag_r;
		logic [N-1:0] body;
		logic rc;
		logic [LW-1:0] k;
		logic signed [LW+1:0] regv;

		assign op_nz[i] = |op[i][N-2:0];
		assign op_nar[i] = op[i][N-1] & ~op_nz[i];
		assign op_zero[i] = ~op[i][N-1] & ~op_nz[i];

		always_comb begin
			mag = op[i][N-1] ? -op[i] : op[i];
			rc = mag[N-2];                          // Regime run polarity
			mag_r = rc ? ~mag : mag;
			k = lead_zeros({mag_r[N-2:0], rc});     // rc closes an all-ones run
			regv = rc ? $signed({2'b00, k - 1'b1}) : -$signed({2'b00, k});
			body = {mag[N-3:0], 2'b00} << k;        // Exponent lands on top
		end

		assign op_scale[i] = {regv, body[N-1 -: ES]};   // regime * 2^ES + exp
		assign op_mant[i] = {op_nz[i], body[N-ES-1:0]}; // Hidden bit cleared for zero
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 1 register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			vld_o <= 1'b0;
		else
			vld_o <= start_i;
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			sign_o <= in1_i[N-1] ^ in2_i[N-1];
			inf_o <= op_nar[0] | op_zero[1];   // NaR / x, x / 0
			zero_o <= op_zero[0] | op_nar[1];  // 0 / x, x / NaR
			scale1_o <= op_scale[0];
			scale2_o <= op_scale[1];
			mant1_o <= op_mant[0];
			mant2_o <= op_mant[1];
		end
	end

endmodule

`default_nettype wire

//--- posit_recip.sv
/* Divisor reciprocal: elaborated seed table and one Newton-Raphson step */
`timescale 1ns/1ns
`default_nettype none

module posit_recip #(
	parameter int ES = 2,
	localparam int MANT_W = posit_div_pkg::POSIT_N - ES
) (
	input  logic [MANT_W:0] mant_i,   // 1.f
	output logic [MANT_W:0] recip_o   // 0.r, weight of MSB is 1/2
);
	localparam int AW = posit_div_pkg::RECIP_AW;
	localparam int DW = posit_div_pkg::RECIP_DW;
	localparam int PW = DW + MANT_W + 1;   // Seed times divisor
	localparam int TW = MANT_W + 2;        // Truncated correction 1.t
	localparam int XW = DW + TW;

	// 2^18 / (2a + 513), i.e. 1/d at the midpoint of the address interval
	function automatic logic [DW-1:0] seed_of(input int a);
		int q;
		q = (1 << (2 * DW)) / (2 * a + (1 << DW) + 1);
		if (q > (1 << DW) - 1)
			q = (1 << DW) - 1;
		return DW'(q);
	endfunction

	logic [DW-1:0] seed_tab [1 << AW];
	logic [DW-1:0] seed;
	logic [PW-1:0] prod;
	logic [PW:0] corr;
	logic [TW-1:0] corr_t;
	logic [XW-1:0] x1;

	for (genvar a = 0; a < (1 << AW); a++) begin : g_seed
		assign seed_tab[a] = seed_of(a);
	end

	assign seed = seed_tab[mant_i[MANT_W-1 -: AW]];

	//////////////////////////////////////////////////////////////////////
	// x1 = x0 * (2 - x0 * d)
	//////////////////////////////////////////////////////////////////////

	assign prod = seed * mant_i;                        // Close to 1.0
	assign corr = {1'b1, {PW{1'b0}}} - {1'b0, prod};   // 2 - x0*d
	assign corr_t = corr[PW-1 -: TW];
	assign x1 = seed * corr_t;

	// NR approaches 1/d from below, so x1 never reaches one
	assign recip_o = x1[XW-2 -: MANT_W+1];

endmodule

`default_nettype wire

//--- posit_divide_core.sv
/* Processing stage: mantissa quotient with power-of-two bypass,
   normalization, scale difference with borrow, second pipeline register */
`timescale 1ns/1ns
`default_nettype none

module posit_divide_core #(
	parameter int ES = 2,
	localparam int MANT_W = posit_div_pkg::POSIT_N - ES,
	localparam int SCALE_W = posit_div_pkg::LOG2_N + ES + 2
) (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      vld_i,
	input  logic                      sign_i,
	input  logic                      inf_i,
	input  logic                      zero_i,
	input  logic signed [SCALE_W-1:0] scale1_i,
	input  logic signed [SCALE_W-1:0] scale2_i,
	input  logic [MANT_W:0]           mant1_i,
	input  logic [MANT_W:0]           mant2_i,
	output logic                      vld_o,
	output logic                      sign_o,
	output logic                      inf_o,
	output logic                      zero_o,
	output logic signed [SCALE_W:0]   scale_o,
	output logic [2*MANT_W+1:0]       frac_o
);
	localparam int QW = 2 * MANT_W + 2;   // Quotient 1.q, one bit per weight

	logic [MANT_W:0] recip;
	logic [QW-1:0] prod;
	logic [QW-1:0] quo;
	logic [QW-1:0] quo_n;
	logic byp;
	logic below;
	logic signed [SCALE_W:0] scale_d;

	posit_recip #(
		.ES(ES)
	) u_recip (
		.mant_i (mant2_i),
		.recip_o(recip)
	);

	assign byp = ~|mant2_i[MANT_W-1:0];   // Divisor is a power of two

	assign prod = mant1_i * recip;
	assign quo = byp ? {mant1_i, {(MANT_W + 1){1'b0}}} : prod;

	//////////////////////////////////////////////////////////////////////
	// Normalize to [1, 2)
	//////////////////////////////////////////////////////////////////////

	assign below = ~quo[QW-1];
	assign quo_n = below ? quo << 1 : quo;

	assign scale_d = scale1_i - scale2_i - $signed({1'b0, below});

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			vld_o <= 1'b0;
		else
			vld_o <= vld_i;
	end

	always_ff @(posedge clk) begin
		if (vld_i) begin
			sign_o <= sign_i;
			inf_o <= inf_i;
			zero_o <= zero_i;
			scale_o <= scale_d;
			frac_o <= quo_n;
		end
	end

endmodule

`default_nettype wire

//--- posit_encode.sv
/* Output stage: regime and exponent packing, round to nearest even,
   re-negation, special values and the final pipeline register */
`timescale 1ns/1ns
`default_nettype none

module posit_encode #(
	parameter int ES = 2,
	localparam int N = posit_div_pkg::POSIT_N,
	localparam int MANT_W = N - ES,
	localparam int SCALE_W = posit_div_pkg::LOG2_N + ES + 2
) (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    vld_i,
	input  logic                    sign_i,
	input  logic                    inf_i,
	input  logic                    zero_i,
	input  logic signed [SCALE_W:0] scale_i,
	input  logic [2*MANT_W+1:0]     frac_i,
	output logic                    done_o,
	output logic [N-1:0]            out_o,
	output logic                    inf_o,
	output logic                    zero_o
);
	localparam int LW = posit_div_pkg::LOG2_N;
	localparam int RW = SCALE_W + 1 - ES;          // Regime value width
	localparam int VW = 2 + ES + 2 * MANT_W + 1 + N;  // Room for the right shift

	logic neg;
	logic signed [RW-1:0] k;
	logic [RW-1:0] run;
	logic sat;
	logic signed [VW-1:0] vec;
	logic signed [VW-1:0] shv;
	logic [N-2:0] body;
	logic [N-2:0] body_rnd;
	logic lsb;
	logic grd;
	logic rnd;
	logic stk;
	logic ulp;
	logic [N-1:0] mag;
	logic [N-1:0] res;

	//////////////////////////////////////////////////////////////////////
	// Regime run and packing
	//////////////////////////////////////////////////////////////////////

	assign neg = scale_i[SCALE_W];
	assign k = scale_i[SCALE_W:ES];      // floor(scale / 2^ES)
	assign run = neg ? ~k : k;           // Extra run bits beyond the first

	// Regime alone fills the body, so no bits are left to round
	assign sat = run >= RW'(N - 2);

	// 10 seeds a ones run, 01 a zeros run, the sign fill stretches it
	assign vec = {~neg, neg, scale_i[ES-1:0], frac_i[2*MANT_W:0], {N{1'b0}}};
	assign shv = vec >>> run[LW-1:0];

	assign body = shv[VW-1 -: N-1];
	assign lsb = shv[VW-N+1];
	assign grd = shv[VW-N];
	assign rnd = shv[VW-N-1];
	assign stk = |shv[VW-N-2:0];

	//////////////////////////////////////////////////////////////////////
	// Round to nearest even, then saturate at maxpos / minpos
	//////////////////////////////////////////////////////////////////////

	assign ulp = grd & (lsb | rnd | stk);

	always_comb begin
		if (!sat)
			body_rnd = body + ulp;
		else if (neg)
			body_rnd = (N-1)'(1);          // minpos, never round to zero
		else
			body_rnd = '1;                 // maxpos
	end

	assign mag = {1'b0, body_rnd};
	assign res = sign_i ? -mag : mag;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			done_o <= 1'b0;
		else
			done_o <= vld_i;
	end

	always_ff @(posedge clk) begin
		if (vld_i) begin
			inf_o <= inf_i;
			zero_o <= zero_i;
			if (inf_i)
				out_o <= {1'b1, {(N - 1){1'b0}}};   // NaR
			else if (zero_i)
				out_o <= '0;
			else
				out_o <= res;
		end
	end

endmodule

`default_nettype wire

//--- posit_div_top.sv
/* Three-stage pipelined posit divider: decode, divide, encode */
`timescale 1ns/1ns
`default_nettype none

module posit_div_top #(
	parameter int ES = 2,
	localparam int N = posit_div_pkg::POSIT_N,
	localparam int MANT_W = N - ES,
	localparam int SCALE_W = posit_div_pkg::LOG2_N + ES + 2
) (
	input  logic         clk,
	input  logic         arst_n_i,
	input  logic         start_i,
	input  logic [N-1:0] in1_i,      // Dividend
	input  logic [N-1:0] in2_i,      // Divisor
	output logic [N-1:0] out_o,
	output logic         inf_o,
	output logic         zero_o,
	output logic         done_o
);
	// Decode to divide
	logic d_vld;
	logic d_sign;
	logic d_inf;
	logic d_zero;
	logic signed [SCALE_W-1:0] d_scale1;
	logic signed [SCALE_W-1:0] d_scale2;
	logic [MANT_W:0] d_mant1;
	logic [MANT_W:0] d_mant2;

	// Divide to encode
	logic c_vld;
	logic c_sign;
	logic c_inf;
	logic c_zero;
	logic signed [SCALE_W:0] c_scale;
	logic [2*MANT_W+1:0] c_frac;

	posit_decode #(.ES(ES)) u_decode (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.start_i (start_i),
		.in1_i   (in1_i),
		.in2_i   (in2_i),
		.vld_o   (d_vld),
		.sign_o  (d_sign),
		.inf_o   (d_inf),
		.zero_o  (d_zero),
		.scale1_o(d_scale1),
		.scale2_o(d_scale2),
		.mant1_o (d_mant1),
		.mant2_o (d_mant2)
	);

	posit_divide_core #(.ES(ES)) u_core (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.vld_i   (d_vld),
		.sign_i  (d_sign),
		.inf_i   (d_inf),
		.zero_i  (d_zero),
		.scale1_i(d_scale1),
		.scale2_i(d_scale2),
		.mant1_i (d_mant1),
		.mant2_i (d_mant2),
		.vld_o   (c_vld),
		.sign_o  (c_sign),
		.inf_o   (c_inf),
		.zero_o  (c_zero),
		.scale_o (c_scale),
		.frac_o  (c_frac)
	);

	posit_encode #(.ES(ES)) u_encode (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.vld_i   (c_vld),
		.sign_i  (c_sign),
		.inf_i   (c_inf),
		.zero_i  (c_zero),
		.scale_i (c_scale),
		.frac_i  (c_frac),
		.done_o  (done_o),
		.out_o   (out_o),
		.inf_o   (inf_o),
		.zero_o  (zero_o)
	);

endmodule

`default_nettype wire

//--- posit_div_chk.sv
/* Bound assertions on the divider ports: done latency, done in reset,
   NaR output with the inf flag */
`timescale 1ns/1ns
`default_nettype none

module posit_div_chk (
	input logic                          clk,
	input logic                          arst_n_i,
	input logic                          start_i,
	input logic                          done_i,
	input logic                          inf_i,
	input logic [posit_div_pkg::POSIT_N-1:0] out_i
);
	localparam int N = posit_div_pkg::POSIT_N;
	localparam int DEPTH = posit_div_pkg::PIPE_DEPTH;

	a_done_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
		done_i == $past(start_i, DEPTH))
		else $error("done_o is not start_i delayed by %0d cycles", DEPTH);

	a_done_reset: assert property (@(posedge clk) !arst_n_i |-> !done_i)
		else $error("done_o high during reset");

	a_inf_nar: assert property (@(posedge clk) disable iff (!arst_n_i)
		done_i && inf_i |-> out_i == {1'b1, {(N - 1){1'b0}}})
		else $error("out_o is not NaR while inf_o is set");   // Flags rule

endmodule

bind posit_div_top posit_div_chk u_chk (
	.clk     (clk),
	.arst_n_i(arst_n_i),
	.start_i (start_i),
	.done_i  (done_o),
	.inf_i   (inf_o),
	.out_i   (out_o)
);

`default_nettype wire

//--- tb_posit_div.sv
/* Testbench for the pipelined posit divider: directed tests against
   a real-valued posit model */
`timescale 1ns/1ns
`default_nettype none

module tb_posit_div;

	localparam int N = posit_div_pkg::POSIT_N;
	localparam int ES = 2;
	localparam int DEPTH = posit_div_pkg::PIPE_DEPTH;
	localparam int MAX_SCALE = (N - 2) * (1 << ES);   // log2 of maxpos

	localparam int N_SPEC = 8;
	localparam int N_POW = 40;
	localparam int N_SYM = 20;
	localparam int N_RAND = 200;
	localparam int N_B2B = 8;
	localparam int TOTAL_CYC = 20 + (N_SPEC + N_POW + 4 * N_SYM + N_RAND) * (DEPTH + 1)
		+ N_B2B + DEPTH + 2;

	logic clk;
	logic arst_n_i;
	logic start_i;
	logic [N-1:0] in1_i;
	logic [N-1:0] in2_i;
	logic [N-1:0] out_o;
	logic inf_o;
	logic zero_o;
	logic done_o;
	integer seed = 32'hb366_fc9b;

	posit_div_top #(.ES(ES)) UUT (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.start_i (start_i),
		.in1_i   (in1_i),
		.in2_i   (in2_i),
		.out_o   (out_o),
		.inf_o   (inf_o),
		.zero_o  (zero_o),
		.done_o  (done_o)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Real-valued posit model
	//////////////////////////////////////////////////////////////////////

	function automatic real pow2(input int e);
		real r;
		r = 1.0;
		for (int i = 0; i < (e < 0 ? -e : e); i++)
			r = (e < 0) ? r / 2.0 : r * 2.0;
		return r;
	endfunction

	function automatic real to_real(input logic [N-1:0] p);
		logic [N-1:0] mag;
		logic rc;
		int i;
		int run;
		int k;
		int ex;
		real frac;
		real w;
		if (p == '0)
			return 0.0;
		mag = p[N-1] ? -p : p;
		rc = mag[N-2];
		run = 0;
		i = N - 2;
		while (i >= 0 && mag[i] == rc) begin
			run++;
			i--;
		end
		k = rc ? run - 1 : -run;
		i--;                                // Skip the run terminator
		ex = 0;
		for (int j = 0; j < ES; j++) begin
			ex = ex * 2;                    // Cut-off exponent bits read as zero
			if (i >= 0) begin
				if (mag[i])
					ex = ex + 1;
				i--;
			end
		end
		frac = 1.0;
		w = 0.5;
		for (; i >= 0; i--) begin
			if (mag[i])
				frac = frac + w;
			w = w / 2.0;
		end
		frac = frac * pow2(k * (1 << ES) + ex);
		return p[N-1] ? -frac : frac;
	endfunction

	// Nearest posit, ties to even on the bit string, clamped to maxpos and minpos
	function automatic logic [N-1:0] to_posit(input real x);
		logic [63:0] bits;
		logic [N-1:0] mag;
		logic neg;
		logic grd;
		logic stk;
		real y;
		real f;
		int e;
		int k;
		int ex;
		int pos;
		if (x == 0.0)
			return '0;
		neg = x < 0.0;
		y = neg ? -x : x;
		e = 0;
		while (y >= 2.0) begin
			y = y / 2.0;
			e++;
		end
		while (y < 1.0) begin
			y = y * 2.0;
			e--;
		end
		if (e >= MAX_SCALE)
			mag = {1'b0, {(N - 1){1'b1}}};
		else if (e < -MAX_SCALE)
			mag = N'(1);
		else begin
			k = (e >= 0) ? e / (1 << ES) : -((-e + (1 << ES) - 1) / (1 << ES));
			ex = e - k * (1 << ES);
			bits = '0;
			pos = 63;
			if (k >= 0) begin
				pos = pos - k - 2;          // Ones run plus its closing zero
				for (int j = 0; j <= k; j++)
					bits[63 - j] = 1'b1;
			end else begin
				pos = pos + k;
				bits[pos] = 1'b1;
				pos--;
			end
			for (int j = ES - 1; j >= 0; j--) begin
				bits[pos] = ex[j];
				pos--;
			end
			f = y - 1.0;
			for (; pos >= 0; pos--) begin
				f = f * 2.0;
				if (f >= 1.0) begin
					bits[pos] = 1'b1;
					f = f - 1.0;
				end
			end
			grd = bits[64-N];
			stk = (|bits[63-N:0]) || (f > 0.0);
			mag = {1'b0, bits[63 -: N-1]};
			mag = mag + N'(grd & (mag[0] | stk));
		end
		return neg ? -mag : mag;
	endfunction

	function automatic logic [N-1:0] model_quotient(input logic [N-1:0] a, input logic [N-1:0] b);
		return to_posit(to_real(a) / to_real(b));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run;
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// Posit codes are monotonic as signed integers, so tol 1 means adjacent code
	task automatic check(input string name, input logic signed [31:0] got,
			input logic signed [31:0] exp, input int tol);
		int diff;
		diff = got - exp;
		if (diff < 0)
			diff = -diff;
		if ($isunknown(got) || diff > tol) begin   // X or Z is a mismatch too
			$display("FAIL at %0t ns: %s got 0x%h expected 0x%h", $time, name,
				got[15:0], exp[15:0]);
			stop_run();
		end
	endtask

	task automatic rand_operand(output logic [N-1:0] v);
		v = N'($random(seed));
		while (v[N-2:0] == '0)              // Neither zero nor NaR
			v = N'($random(seed));
	endtask

	task automatic run_op(input logic [N-1:0] a, input logic [N-1:0] b,
			output logic [N-1:0] res, output logic inf, output logic zero);
		int cnt;
		logic seen;
		@(posedge clk);
		#2;
		in1_i = a;
		in2_i = b;
		start_i = 1'b1;
		cnt = 0;
		seen = 1'b0;
		while (!seen && cnt < 8) begin
			@(posedge clk);
			#2;
			start_i = 1'b0;
			cnt++;
			@(negedge clk);
			seen = done_o;
		end
		if (!seen) begin
			$display("Error: done_o never rose after start_i at %0t ns", $time);
			stop_run();
		end
		check("done_o latency", cnt, DEPTH, 0);
		res = out_o;
		inf = inf_o;
		zero = zero_o;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset;
		repeat (10) begin
			@(negedge clk);
			check("done_o", done_o, 0, 0);
		end
		@(posedge clk);
		#2;
		arst_n_i = 1'b1;
		repeat (5) begin
			@(negedge clk);
			check("done_o", done_o, 0, 0);
		end
	endtask

	task automatic special_case(input logic [N-1:0] a, input logic [N-1:0] b);
		logic [N-1:0] res;
		logic inf;
		logic zero;
		logic exp_inf;
		logic exp_zero;
		exp_inf = (a == {1'b1, {(N - 1){1'b0}}}) || (b == '0);
		exp_zero = (a == '0) || (b == {1'b1, {(N - 1){1'b0}}});
		run_op(a, b, res, inf, zero);
		check("inf_o", inf, exp_inf, 0);
		check("zero_o", zero, exp_zero, 0);
		check("out_o", res, exp_inf ? 'h8000 : 0, 0);
	endtask

	task automatic test_specials;
		special_case(16'h0000, 16'h4000);
		special_case(16'h8000, 16'h4000);
		special_case(16'h4000, 16'h0000);
		special_case(16'h0000, 16'h0000);
		special_case(16'hc000, 16'h8000);
		special_case(16'h8000, 16'h0000);
		special_case(16'h0000, 16'h8000);
		special_case(16'h1234, 16'h8000);
	endtask

	task automatic test_pow2;
		logic [N-1:0] a;
		logic [N-1:0] b;
		logic [N-1:0] res;
		logic inf;
		logic zero;
		int j;
		repeat (N_POW) begin
			rand_operand(a);
			j = $random(seed) % 33;
			b = to_posit(pow2(j));
			if ($random(seed) & 1)
				b = -b;
			run_op(a, b, res, inf, zero);
			check("out_o", $signed(res), $signed(model_quotient(a, b)), 0);
			check("inf_o", inf, 0, 0);
			check("zero_o", zero, 0, 0);
		end
	endtask

	task automatic test_symmetry;
		logic [N-1:0] a;
		logic [N-1:0] b;
		logic [N-1:0] r0;
		logic [N-1:0] r;
		logic inf;
		logic zero;
		repeat (N_SYM) begin
			rand_operand(a);
			rand_operand(b);
			a = a[N-1] ? -a : a;
			b = b[N-1] ? -b : b;
			run_op(a, b, r0, inf, zero);
			check("out_o", $signed(r0), $signed(model_quotient(a, b)), 1);
			run_op(-a, b, r, inf, zero);
			check("out_o neg dividend", $signed(r), $signed(-r0), 0);
			run_op(a, -b, r, inf, zero);
			check("out_o neg divisor", $signed(r), $signed(-r0), 0);
			run_op(-a, -b, r, inf, zero);
			check("out_o neg both", $signed(r), $signed(r0), 0);
		end
	endtask

	task automatic test_random;
		logic [N-1:0] a;
		logic [N-1:0] b;
		logic [N-1:0] res;
		logic inf;
		logic zero;
		repeat (N_RAND) begin
			rand_operand(a);
			rand_operand(b);
			run_op(a, b, res, inf, zero);
			check("out_o", $signed(res), $signed(model_quotient(a, b)), 1);
			check("inf_o", inf, 0, 0);
			check("zero_o", zero, 0, 0);
		end
	endtask

	task automatic test_back_to_back;
		logic [N-1:0] qa [N_B2B];
		logic [N-1:0] qb [N_B2B];
		logic [N-1:0] qe [N_B2B];
		logic busy;
		for (int i = 0; i < N_B2B; i++) begin
			rand_operand(qa[i]);
			rand_operand(qb[i]);
			qe[i] = model_quotient(qa[i], qb[i]);
		end
		for (int c = 0; c < N_B2B + DEPTH + 1; c++) begin
			@(posedge clk);
			#2;
			start_i = (c < N_B2B);
			if (c < N_B2B) begin
				in1_i = qa[c];
				in2_i = qb[c];
			end
			@(negedge clk);
			busy = (c >= DEPTH) && (c - DEPTH < N_B2B);   // Result of op c-DEPTH
			check("done_o", done_o, busy, 0);
			if (busy)
				check("out_o", $signed(out_o), $signed(qe[c-DEPTH]), 1);
		end
	endtask

	initial begin
		clk = 1'b0;
		arst_n_i = 1'b0;
		start_i = 1'b0;
		in1_i = '0;
		in2_i = '0;
		test_reset();
		test_specials();
		test_pow2();
		test_symmetry();
		test_random();
		test_back_to_back();
		$display("PASS: all tests");
		$finish;
	end

	// Watchdog
	initial begin
		#(TOTAL_CYC * 20 + 2000);
		$display("Timeout: the tests did not finish in the expected time");
		stop_run();
	end

endmodule

`default_nettype wire

//--- build.f
posit_div_pkg.sv
posit_decode.sv
posit_recip.sv
posit_divide_core.sv
posit_encode.sv
posit_div_top.sv
posit_div_chk.sv
tb_posit_div.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_posit_div
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
